/* hw/id_pkg.sv */
package id_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned WORD_W     = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // Data and instruction word
  typedef logic [WORD_W-1:0]     word_t;
  // Register file index
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Major opcodes handled by this stage
  typedef enum logic [6:0] {
    OPCODE_OP     = 7'b0110011,
    OPCODE_OP_IMM = 7'b0010011,
    OPCODE_LUI    = 7'b0110111,
    OPCODE_AUIPC  = 7'b0010111,
    OPCODE_BRANCH = 7'b1100011
  } opcode_e;

  // ALU operators, comparisons and divider ops share one space
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU,
    ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
  } alu_op_e;

  // Operand A source
  typedef enum logic [1:0] {OP_A_REG_A, OP_A_PC, OP_A_ZERO} op_a_sel_e;

  // Operand B source
  typedef enum logic {OP_B_REG_B, OP_B_IMM} op_b_sel_e;

  // Immediate format
  typedef enum logic [1:0] {IMM_I, IMM_U, IMM_B} imm_sel_e;

  // ID/EX state
  typedef enum logic {FIRST_CYCLE, MULTI_CYCLE} id_fsm_e;

endpackage

/* hw/id_ctrl_if.sv */
`timescale 1ns/100ps

interface id_ctrl_if import id_pkg::*; ();

  // ALU control
  alu_op_e   alu_op;
  op_a_sel_e op_a_sel;
  op_b_sel_e op_b_sel;
  imm_sel_e  imm_sel;

  // Instruction class and write enable
  logic      rf_we;
  logic      branch;
  logic      div;
  logic      illegal;

  // Decoder owns every field
  modport decoder (
    output alu_op, op_a_sel, op_b_sel, imm_sel,
    output rf_we, branch, div, illegal
  );

  // Operand selection only
  modport operand (input alu_op, op_a_sel, op_b_sel, imm_sel);

  // Sequencing only
  modport fsm (input rf_we, branch, div, illegal);

endinterface

/* hw/id_decoder.sv */
`timescale 1ns/100ps

module id_decoder import id_pkg::*; #(
  parameter bit rv32e = 1'b0
) (
  input  word_t     instr_i,
  id_ctrl_if.decoder ctrl,
  output reg_addr_t rf_raddr_a_o,
  output reg_addr_t rf_raddr_b_o,
  output reg_addr_t rf_waddr_o
);

  // Instruction fields
  opcode_e   opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;

  // Raw decode before legality and x0 masking
  logic dec_we;
  logic dec_illegal;
  logic rs1_used;
  logic rs2_used;
  logic reg_illegal;
  logic insn_illegal;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign funct7 = instr_i[31:25];

  // Register file ports follow the fixed field positions
  assign rf_raddr_a_o = rs1;
  assign rf_raddr_b_o = rs2;
  assign rf_waddr_o   = rd;

  //////////////////////////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ctrl.alu_op   = ALU_ADD;
    ctrl.op_a_sel = OP_A_REG_A;
    ctrl.op_b_sel = OP_B_REG_B;
    ctrl.imm_sel  = IMM_I;
    dec_we        = 1'b0;
    dec_illegal   = 1'b0;
    rs1_used      = 1'b0;
    rs2_used      = 1'b0;
    ctrl.branch   = 1'b0;
    ctrl.div      = 1'b0;
    unique case (opcode)
      OPCODE_OP: begin
        dec_we   = 1'b1;
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        unique case (funct7)
          7'b0000000: begin
            unique case (funct3)
              3'b000:  ctrl.alu_op = ALU_ADD;
              3'b001:  ctrl.alu_op = ALU_SLL;
              3'b010:  ctrl.alu_op = ALU_SLT;
              3'b011:  ctrl.alu_op = ALU_SLTU;
              3'b100:  ctrl.alu_op = ALU_XOR;
              3'b101:  ctrl.alu_op = ALU_SRL;
              3'b110:  ctrl.alu_op = ALU_OR;
              default: ctrl.alu_op = ALU_AND;
            endcase
          end
          7'b0100000: begin
            if (funct3 == 3'b000) ctrl.alu_op = ALU_SUB;
            else if (funct3 == 3'b101) ctrl.alu_op = ALU_SRA;
            else dec_illegal = 1'b1;
          end
          7'b0000001: begin
            // Upper half of M is divide, lower half is multiply (no multiplier here)
            ctrl.div    = funct3[2];
            dec_illegal = ~funct3[2];
            unique case (funct3[1:0])
              2'b00:   ctrl.alu_op = ALU_DIV;
              2'b01:   ctrl.alu_op = ALU_DIVU;
              2'b10:   ctrl.alu_op = ALU_REM;
              default: ctrl.alu_op = ALU_REMU;
            endcase
          end
          default: dec_illegal = 1'b1;
        endcase
      end
      OPCODE_OP_IMM: begin
        dec_we        = 1'b1;
        rs1_used      = 1'b1;
        ctrl.op_b_sel = OP_B_IMM;
        unique case (funct3)
          3'b000: ctrl.alu_op = ALU_ADD;
          3'b010: ctrl.alu_op = ALU_SLT;
          3'b011: ctrl.alu_op = ALU_SLTU;
          3'b100: ctrl.alu_op = ALU_XOR;
          3'b110: ctrl.alu_op = ALU_OR;
          3'b111: ctrl.alu_op = ALU_AND;
          3'b001: begin
            ctrl.alu_op = ALU_SLL;
            dec_illegal = (funct7 != 7'b0000000);
          end
          default: begin
            // Shift right, funct7 picks logical or arithmetic
            ctrl.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            dec_illegal = ({funct7[6], funct7[4:0]} != 6'b0);
          end
        endcase
      end
      OPCODE_LUI: begin
        dec_we        = 1'b1;
        ctrl.op_a_sel = OP_A_ZERO;
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.imm_sel  = IMM_U;
      end
      OPCODE_AUIPC: begin
        dec_we        = 1'b1;
        ctrl.op_a_sel = OP_A_PC;
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.imm_sel  = IMM_U;
      end
      OPCODE_BRANCH: begin
        rs1_used     = 1'b1;
        rs2_used     = 1'b1;
        ctrl.branch  = 1'b1;
        // Target cycle uses the B immediate
        ctrl.imm_sel = IMM_B;
        unique case (funct3)
          3'b000:  ctrl.alu_op = ALU_EQ;
          3'b001:  ctrl.alu_op = ALU_NE;
          3'b100:  ctrl.alu_op = ALU_LT;
          3'b101:  ctrl.alu_op = ALU_GE;
          3'b110:  ctrl.alu_op = ALU_LTU;
          3'b111:  ctrl.alu_op = ALU_GEU;
          default: dec_illegal = 1'b1;
        endcase
      end
      default: dec_illegal = 1'b1;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Legality and write enable
  //////////////////////////////////////////////////////////////////////

  // RV32E has only x0..x15
  assign reg_illegal  = rv32e && ((rs1_used && rs1[4]) || (rs2_used && rs2[4]) ||
                                  (dec_we && rd[4]));
  assign insn_illegal = dec_illegal | reg_illegal;
  assign ctrl.illegal = insn_illegal;

  // No write for illegal instructions or x0
  assign ctrl.rf_we = dec_we & ~insn_illegal & (rd != '0);

endmodule

/* hw/id_operand_mux.sv */
`timescale 1ns/100ps

module id_operand_mux import id_pkg::*; (
  input  word_t      instr_i,
  input  word_t      pc_i,
  input  word_t      rf_rdata_a_i,
  input  word_t      rf_rdata_b_i,
  input  logic       second_cycle_i,
  id_ctrl_if.operand ctrl,
  output alu_op_e    alu_operator_o,
  output word_t      alu_operand_a_o,
  output word_t      alu_operand_b_o
);

  word_t imm_i;
  word_t imm_u;
  word_t imm_b;
  word_t imm;

  // Immediate extraction and sign extension
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};

  always_comb begin
    unique case (ctrl.imm_sel)
      IMM_U:   imm = imm_u;
      IMM_B:   imm = imm_b;
      default: imm = imm_i;
    endcase
  end

  // Branch target cycle forces PC + B immediate through the adder
  assign alu_operator_o = second_cycle_i ? ALU_ADD : ctrl.alu_op;

  always_comb begin
    if (second_cycle_i) begin
      alu_operand_a_o = pc_i;
    end else begin
      unique case (ctrl.op_a_sel)
        OP_A_PC:   alu_operand_a_o = pc_i;
        OP_A_ZERO: alu_operand_a_o = '0;
        default:   alu_operand_a_o = rf_rdata_a_i;
      endcase
    end
  end

  // Branches decode the B format, so the target cycle takes the selected immediate
  assign alu_operand_b_o = second_cycle_i                 ? imm   :
                           (ctrl.op_b_sel == OP_B_IMM)    ? imm   : rf_rdata_b_i;

endmodule

/* hw/id_ex_fsm.sv */
`timescale 1ns/100ps

module id_ex_fsm import id_pkg::*; (
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   instr_valid_i,
  input  logic   branch_decision_i,
  input  logic   ex_valid_i,
  id_ctrl_if.fsm ctrl,
  output logic   second_cycle_o,
  output logic   id_in_ready_o,
  output logic   pc_set_o,
  output logic   div_en_o,
  output logic   rf_we_o,
  output logic   illegal_insn_o
);

  id_fsm_e state_q;
  id_fsm_e state_d;

  //////////////////////////////////////////////////////////////////////
  // Next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    second_cycle_o = 1'b0;
    id_in_ready_o  = 1'b0;
    pc_set_o       = 1'b0;
    div_en_o       = 1'b0;
    rf_we_o        = 1'b0;
    illegal_insn_o = 1'b0;
    unique case (state_q)
      FIRST_CYCLE: begin
        if (instr_valid_i) begin
          if (ctrl.illegal) begin
            // Retire at once, nothing written
            illegal_insn_o = 1'b1;
            id_in_ready_o  = 1'b1;
          end else if (ctrl.div) begin
            // Kick the divider, then wait for its result
            div_en_o = 1'b1;
            state_d  = MULTI_CYCLE;
          end else if (ctrl.branch) begin
            // Taken branch needs a second cycle for the target
            if (branch_decision_i) state_d = MULTI_CYCLE;
            else id_in_ready_o = 1'b1;
          end else begin
            id_in_ready_o = 1'b1;
            rf_we_o       = ctrl.rf_we;
          end
        end
      end
      MULTI_CYCLE: begin
        if (ctrl.branch) begin
          // Target is on the ALU this cycle
          second_cycle_o = 1'b1;
          pc_set_o       = 1'b1;
          id_in_ready_o  = 1'b1;
          state_d        = FIRST_CYCLE;
        end else if (ctrl.div) begin
          if (ex_valid_i) begin
            id_in_ready_o = 1'b1;
            rf_we_o       = ctrl.rf_we;
            state_d       = FIRST_CYCLE;
          end
        end else begin
          state_d = FIRST_CYCLE; // nothing to finish
        end
      end
      default: state_d = FIRST_CYCLE;
    endcase
  end

  // State register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= FIRST_CYCLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* hw/id_stage.sv */
`timescale 1ns/100ps

module id_stage import id_pkg::*; #(
  parameter bit rv32e = 1'b0
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      instr_valid_i,

  // Instruction, PC and register read data
  input  word_t     instr_rdata_i,
  input  word_t     pc_id_i,
  input  word_t     rf_rdata_a_i,
  input  word_t     rf_rdata_b_i,

  // From the ALU and the divider
  input  logic      branch_decision_i,
  input  logic      ex_valid_i,

  // Control out
  output logic      id_in_ready_o,
  output logic      illegal_insn_o,
  output logic      pc_set_o,
  output logic      div_en_ex_o,

  // ALU
  output alu_op_e   alu_operator_ex_o,
  output word_t     alu_operand_a_ex_o,
  output word_t     alu_operand_b_ex_o,

  // Register file
  output reg_addr_t rf_raddr_a_o,
  output reg_addr_t rf_raddr_b_o,
  output reg_addr_t rf_waddr_id_o,
  output logic      rf_we_id_o
);

  // Decoded control shared by the three blocks
  id_ctrl_if ctrl_if ();

  // Operand override for the branch target cycle
  logic second_cycle;

  id_decoder #(
    .rv32e (rv32e)
  ) id_decoder_inst (
    .instr_i      (instr_rdata_i),
    .ctrl         (ctrl_if.decoder),
    .rf_raddr_a_o (rf_raddr_a_o),
    .rf_raddr_b_o (rf_raddr_b_o),
    .rf_waddr_o   (rf_waddr_id_o)
  );

  id_operand_mux id_operand_mux_inst (
    .instr_i         (instr_rdata_i),
    .pc_i            (pc_id_i),
    .rf_rdata_a_i    (rf_rdata_a_i),
    .rf_rdata_b_i    (rf_rdata_b_i),
    .second_cycle_i  (second_cycle),
    .ctrl            (ctrl_if.operand),
    .alu_operator_o  (alu_operator_ex_o),
    .alu_operand_a_o (alu_operand_a_ex_o),
    .alu_operand_b_o (alu_operand_b_ex_o)
  );

  id_ex_fsm id_ex_fsm_inst (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .instr_valid_i     (instr_valid_i),
    .branch_decision_i (branch_decision_i),
    .ex_valid_i        (ex_valid_i),
    .ctrl              (ctrl_if.fsm),
    .second_cycle_o    (second_cycle),
    .id_in_ready_o     (id_in_ready_o),
    .pc_set_o          (pc_set_o),
    .div_en_o          (div_en_ex_o),
    .rf_we_o           (rf_we_id_o),
    .illegal_insn_o    (illegal_insn_o)
  );

endmodule

/* testbench/id_stage_assertions.sv */
`timescale 1ns/100ps

module id_stage_assertions (
  input logic clk_i,
  input logic reset_i,
  input logic pc_set_o,
  input logic id_in_ready_o,
  input logic div_en_ex_o
);

  //////////////////////////////////////////////////////////////////////
  // Stage timing rules
  //////////////////////////////////////////////////////////////////////

  // Branch target cycle also retires the branch
  pc_set_ready_a : assert property (@(posedge clk_i) disable iff (reset_i)
    pc_set_o |-> id_in_ready_o)
    else $error("pc_set_o raised without id_in_ready_o");

  // Divider kick is a single-cycle strobe
  div_en_pulse_a : assert property (@(posedge clk_i) disable iff (reset_i)
    div_en_ex_o |=> !div_en_ex_o)
    else $error("div_en_ex_o held for more than one cycle");

  // At most one target cycle per branch
  pc_set_single_a : assert property (@(posedge clk_i) disable iff (reset_i)
    pc_set_o |=> !pc_set_o)
    else $error("pc_set_o raised in two consecutive cycles");

endmodule

bind id_stage id_stage_assertions id_stage_assertions_inst (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .pc_set_o      (pc_set_o),
  .id_in_ready_o (id_in_ready_o),
  .div_en_ex_o   (div_en_ex_o)
);

/* testbench/id_stage_tb.sv */
`timescale 1ns/100ps

module id_stage_tb import id_pkg::*; ();

  localparam int NUM_INSTR = 400;
  // Longest divide wait is 8 cycles plus margin
  localparam int TIMEOUT   = 20;

  logic      clk_i;
  logic      reset_i;
  logic      instr_valid_i;
  word_t     instr_rdata_i;
  word_t     pc_id_i;
  word_t     rf_rdata_a_i;
  word_t     rf_rdata_b_i;
  logic      branch_decision_i;
  logic      ex_valid_i;
  logic      id_in_ready_o;
  logic      illegal_insn_o;
  logic      pc_set_o;
  logic      div_en_ex_o;
  alu_op_e   alu_operator_ex_o;
  word_t     alu_operand_a_ex_o;
  word_t     alu_operand_b_ex_o;
  reg_addr_t rf_raddr_a_o;
  reg_addr_t rf_raddr_b_o;
  reg_addr_t rf_waddr_id_o;
  logic      rf_we_id_o;

  // Model state and bookkeeping
  logic [31:0] lfsr_q;
  int          check_count;
  int          error_count;
  logic        timed_out;
  int          cur_idx;
  word_t       cur_instr;
  logic        exp_illegal;
  logic        exp_we;
  logic        exp_branch;
  logic        exp_div;
  alu_op_e     exp_op;
  word_t       exp_a;
  word_t       exp_b;
  word_t       exp_imm_b;

  id_stage #(
    .rv32e (1'b0)
  ) id_stage_inst (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .instr_valid_i      (instr_valid_i),
    .instr_rdata_i      (instr_rdata_i),
    .pc_id_i            (pc_id_i),
    .rf_rdata_a_i       (rf_rdata_a_i),
    .rf_rdata_b_i       (rf_rdata_b_i),
    .branch_decision_i  (branch_decision_i),
    .ex_valid_i         (ex_valid_i),
    .id_in_ready_o      (id_in_ready_o),
    .illegal_insn_o     (illegal_insn_o),
    .pc_set_o           (pc_set_o),
    .div_en_ex_o        (div_en_ex_o),
    .alu_operator_ex_o  (alu_operator_ex_o),
    .alu_operand_a_ex_o (alu_operand_a_ex_o),
    .alu_operand_b_ex_o (alu_operand_b_ex_o),
    .rf_raddr_a_o       (rf_raddr_a_o),
    .rf_raddr_b_o       (rf_raddr_b_o),
    .rf_waddr_id_o      (rf_waddr_id_o),
    .rf_we_id_o         (rf_we_id_o)
  );

  // 100 ns clock
  always #50 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Random source and stimulus
  //////////////////////////////////////////////////////////////////////

  // 32-bit Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // Mostly handled opcodes and one eighth raw random words
  function automatic word_t gen_instr();
    word_t instr;
    instr = take_bits(32);
    case (take_bits(3))
      0, 1: begin
        instr[6:0] = OPCODE_OP;
        case (take_bits(2))
          0:       instr[31:25] = 7'b0000000;
          1:       instr[31:25] = 7'b0100000;
          default: instr[31:25] = 7'b0000001;
        endcase
      end
      2, 3: begin
        instr[6:0] = OPCODE_OP_IMM;
        // Half the time a legal shift encoding
        if (take_bits(1) != 32'd0) begin
          instr[31]    = 1'b0;
          instr[29:25] = 5'b00000;
        end
      end
      4:       instr[6:0] = (take_bits(1) != 32'd0) ? OPCODE_AUIPC : OPCODE_LUI;
      5, 6:    instr[6:0] = OPCODE_BRANCH;
      default: ;
    endcase
    return instr;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Register-register operator for funct7 of zero
  function automatic alu_op_e base_op(input logic [2:0] f3);
    case (f3)
      3'd0:    return ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  task automatic predict(input word_t instr, input word_t pc, input word_t ra,
                         input word_t rb);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       writes;
    f3          = instr[14:12];
    f7          = instr[31:25];
    writes      = 1'b0;
    exp_illegal = 1'b0;
    exp_branch  = 1'b0;
    exp_div     = 1'b0;
    exp_op      = ALU_ADD;
    exp_a       = ra;
    exp_b       = rb;
    exp_imm_b   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    case (instr[6:0])
      7'b0110011: begin
        writes = 1'b1;
        if (f7 == 7'b0000000) exp_op = base_op(f3);
        else if (f7 == 7'b0100000 && f3 == 3'b000) exp_op = ALU_SUB;
        else if (f7 == 7'b0100000 && f3 == 3'b101) exp_op = ALU_SRA;
        else if (f7 == 7'b0000001 && f3[2]) begin
          exp_div = 1'b1;
          case (f3[1:0])
            2'd0:    exp_op = ALU_DIV;
            2'd1:    exp_op = ALU_DIVU;
            2'd2:    exp_op = ALU_REM;
            default: exp_op = ALU_REMU;
          endcase
        end else begin
          // Multiply and unknown funct7
          exp_illegal = 1'b1;
        end
      end
      7'b0010011: begin
        writes = 1'b1;
        exp_op = base_op(f3);
        exp_b  = {{20{instr[31]}}, instr[31:20]};
        if (f3 == 3'b001) exp_illegal = (f7 != 7'b0000000);
        if (f3 == 3'b101) begin
          if (f7 == 7'b0100000) exp_op = ALU_SRA;
          exp_illegal = (f7 != 7'b0000000) && (f7 != 7'b0100000);
        end
      end
      7'b0110111, 7'b0010111: begin
        writes = 1'b1;
        exp_a  = instr[5] ? '0 : pc;
        exp_b  = {instr[31:12], 12'h000};
      end
      7'b1100011: begin
        exp_branch = 1'b1;
        case (f3)
          3'd0:    exp_op = ALU_EQ;
          3'd1:    exp_op = ALU_NE;
          3'd4:    exp_op = ALU_LT;
          3'd5:    exp_op = ALU_GE;
          3'd6:    exp_op = ALU_LTU;
          3'd7:    exp_op = ALU_GEU;
          default: exp_illegal = 1'b1;
        endcase
      end
      default: exp_illegal = 1'b1;
    endcase
    exp_we = writes && !exp_illegal && (instr[11:7] != 5'd0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks and sequences
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input word_t exp, input word_t act);
    check_count++;
    assert (act === exp)
    else begin
      error_count++;
      $display("FAILED %s: expected %h, actual %h (instr %0d = %h)",
               name, exp, act, cur_idx, cur_instr);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_word(name, 32'(exp), 32'(act));
  endtask

  // Every control output stays low without a valid instruction
  task automatic idle_cycle();
    @(posedge clk_i);
    #10;
    instr_valid_i     = 1'b0;
    ex_valid_i        = 1'b0;
    instr_rdata_i     = take_bits(32);
    branch_decision_i = (take_bits(1) != 32'd0);
    #20;
    check_bit("idle.ready", 1'b0, id_in_ready_o);
    check_bit("idle.illegal", 1'b0, illegal_insn_o);
    check_bit("idle.pc_set", 1'b0, pc_set_o);
    check_bit("idle.div_en", 1'b0, div_en_ex_o);
    check_bit("idle.rf_we", 1'b0, rf_we_id_o);
  endtask

  task automatic run_instr();
    int div_lat;
    int cycles;
    cur_instr = gen_instr();
    @(posedge clk_i);
    #10;
    instr_valid_i     = 1'b1;
    instr_rdata_i     = cur_instr;
    pc_id_i           = take_bits(32);
    rf_rdata_a_i      = take_bits(32);
    rf_rdata_b_i      = take_bits(32);
    branch_decision_i = (take_bits(1) != 32'd0);
    ex_valid_i        = 1'b0;
    div_lat           = int'(take_bits(3)) + 1;
    predict(cur_instr, pc_id_i, rf_rdata_a_i, rf_rdata_b_i);
    #20;
    // Cycle 1
    check_word("c1.raddr_a", 32'(cur_instr[19:15]), 32'(rf_raddr_a_o));
    check_word("c1.raddr_b", 32'(cur_instr[24:20]), 32'(rf_raddr_b_o));
    check_word("c1.waddr", 32'(cur_instr[11:7]), 32'(rf_waddr_id_o));
    check_bit("c1.illegal", exp_illegal, illegal_insn_o);
    check_bit("c1.pc_set", 1'b0, pc_set_o);
    check_bit("c1.div_en", exp_div, div_en_ex_o);
    check_bit("c1.rf_we", exp_we && !exp_div, rf_we_id_o);
    check_bit("c1.ready", exp_illegal || !(exp_div || (exp_branch && branch_decision_i)),
              id_in_ready_o);
    if (!exp_illegal) begin
      check_word("c1.operator", 32'(exp_op), 32'(alu_operator_ex_o));
      check_word("c1.operand_a", exp_a, alu_operand_a_ex_o);
      check_word("c1.operand_b", exp_b, alu_operand_b_ex_o);
    end
    // Further cycles until the stage takes the instruction
    cycles = 0;
    while (id_in_ready_o !== 1'b1 && !timed_out) begin
      if (cycles == TIMEOUT) begin
        $display("ERROR: id_in_ready_o did not rise within %0d cycles (instr %0d)",
                 TIMEOUT, cur_idx);
        error_count++;
        timed_out = 1'b1;
      end else begin
        @(posedge clk_i);
        #10;
        cycles++;
        ex_valid_i = exp_div && (cycles == div_lat);
        #20;
        check_bit("mc.div_en", 1'b0, div_en_ex_o);
        check_bit("mc.illegal", 1'b0, illegal_insn_o);
        if (exp_branch) begin
          // Target cycle carries PC plus B immediate
          check_word("target.operator", 32'(ALU_ADD), 32'(alu_operator_ex_o));
          check_word("target.operand_a", pc_id_i, alu_operand_a_ex_o);
          check_word("target.operand_b", exp_imm_b, alu_operand_b_ex_o);
          check_bit("target.pc_set", 1'b1, pc_set_o);
          check_bit("target.ready", 1'b1, id_in_ready_o);
          check_bit("target.rf_we", 1'b0, rf_we_id_o);
        end else begin
          // Operands hold while the divider runs
          check_word("div.operator", 32'(exp_op), 32'(alu_operator_ex_o));
          check_word("div.operand_a", exp_a, alu_operand_a_ex_o);
          check_word("div.operand_b", exp_b, alu_operand_b_ex_o);
          check_bit("div.pc_set", 1'b0, pc_set_o);
          check_bit("div.ready", ex_valid_i, id_in_ready_o);
          check_bit("div.rf_we", ex_valid_i && exp_we, rf_we_id_o);
        end
      end
    end
  endtask

  initial begin
    clk_i             = 1'b0;
    reset_i           = 1'b1;
    instr_valid_i     = 1'b0;
    instr_rdata_i     = '0;
    pc_id_i           = '0;
    rf_rdata_a_i      = '0;
    rf_rdata_b_i      = '0;
    branch_decision_i = 1'b0;
    ex_valid_i        = 1'b0;
    lfsr_q            = 32'd87;
    check_count       = 0;
    error_count       = 0;
    timed_out         = 1'b0;
    cur_idx           = 0;
    cur_instr         = '0;
    repeat (5) @(posedge clk_i);
    #10;
    reset_i = 1'b0;
    idle_cycle();
    for (int i = 0; i < NUM_INSTR && !timed_out; i++) begin
      if (take_bits(2) == 32'd0) idle_cycle();
      cur_idx = i;
      run_instr();
    end
    if (!timed_out) idle_cycle();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* id_stage.f */
hw/id_pkg.sv
hw/id_ctrl_if.sv
hw/id_decoder.sv
hw/id_operand_mux.sv
hw/id_ex_fsm.sv
hw/id_stage.sv
testbench/id_stage_assertions.sv
testbench/id_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator, run, and decide the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module id_stage_tb -f id_stage.f \
  --Mdir obj_dir -o id_stage_sim > sim.log 2>&1 &&
./obj_dir/id_stage_sim >> sim.log 2>&1
grep -qx "test passed" sim.log && echo "simulation: PASS" ||
  { echo "simulation: FAIL, see sim.log"; exit 1; }
